//--- all.f
gin_cfg_pkg.sv
gin_types_pkg.sv
gin_mcc.sv
gin_xbus.sv
gin.sv
gin_id_loader.sv
gin_top.sv
gin_properties.sv
gin_tb.sv

//--- gin.sv
`timescale 1ns/1ps

module gin #(
    parameter int DATA_WIDTH    = gin_cfg_pkg::GIN_DATA_W,
    parameter int ROW_TAG_WIDTH = gin_cfg_pkg::GIN_ROW_TAG_W,
    parameter int COL_TAG_WIDTH = gin_cfg_pkg::GIN_COL_TAG_W,
    parameter int NUM_OF_ROWS   = gin_cfg_pkg::GIN_ROWS,
    parameter int NUM_OF_COLS   = gin_cfg_pkg::GIN_COLS
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  gin_types_pkg::gin_packet_t  pkt,
    input  logic                        enable_in,
    input  logic [NUM_OF_COLS-1:0]      ready_in [NUM_OF_ROWS],
    input  logic                        scan_en_id,
    input  logic                        scan_in_id,
    output logic [DATA_WIDTH-1:0]       data_out [NUM_OF_ROWS][NUM_OF_COLS],
    output logic [NUM_OF_COLS-1:0]      enable_out [NUM_OF_ROWS],
    output logic                        ready_out,
    output logic                        scan_out_id
);

    logic [DATA_WIDTH-1:0]    pkt_data;
    logic [ROW_TAG_WIDTH-1:0] row_tag;
    logic [COL_TAG_WIDTH-1:0] col_tag;

    logic [DATA_WIDTH-1:0]    row_data   [NUM_OF_ROWS]; // Row MCC to its X-bus
    logic [NUM_OF_ROWS-1:0]   row_enable;
    logic [NUM_OF_ROWS-1:0]   row_ready;  // Ready of each row MCC
    logic [NUM_OF_ROWS-1:0]   xbus_ready; // Ready of each X-bus
    logic                     gated_enable;
    logic [2*NUM_OF_ROWS:0]   scan_chain; // Row MCC, then its X-bus, per row

    assign pkt_data = DATA_WIDTH'(pkt.data);
    assign row_tag  = ROW_TAG_WIDTH'(pkt.row_tag);
    assign col_tag  = COL_TAG_WIDTH'(pkt.col_tag);

    assign scan_chain[0] = scan_in_id;
    assign scan_out_id   = scan_chain[2*NUM_OF_ROWS];

    // Every targeted PE must be ready before anything is delivered
    assign ready_out    = &row_ready;
    assign gated_enable = enable_in && ready_out; // All targets or none

    for (genvar r = 0; r < NUM_OF_ROWS; r++) begin : g_row
        gin_mcc #(
            .DATA_WIDTH (DATA_WIDTH),
            .TAG_WIDTH  (ROW_TAG_WIDTH)
        ) row_mcc_i (
            .clk         (clk),
            .rst_n       (rst_n),
            .data_in     (pkt_data),
            .tag         (row_tag),
            .enable_in   (gated_enable),
            .ready_in    (xbus_ready[r]),
            .scan_en_id  (scan_en_id),
            .scan_in_id  (scan_chain[2*r]),
            .data_out    (row_data[r]),
            .enable_out  (row_enable[r]),
            .ready_out   (row_ready[r]),
            .scan_out_id (scan_chain[2*r+1])
        );

        gin_xbus #(
            .DATA_WIDTH    (DATA_WIDTH),
            .COL_TAG_WIDTH (COL_TAG_WIDTH),
            .NUM_OF_COLS   (NUM_OF_COLS)
        ) xbus_i (
            .clk         (clk),
            .rst_n       (rst_n),
            .data_in     (row_data[r]),
            .col_tag     (col_tag),
            .enable_in   (row_enable[r]),
            .ready_in    (ready_in[r]),
            .scan_en_id  (scan_en_id),
            .scan_in_id  (scan_chain[2*r+1]),
            .data_out    (data_out[r]),
            .enable_out  (enable_out[r]),
            .ready_out   (xbus_ready[r]),
            .scan_out_id (scan_chain[2*r+2])
        );
    end

endmodule

//--- gin_cfg_pkg.sv
package gin_cfg_pkg;

    // Payload carried to every matching PE
    localparam int GIN_DATA_W = 16;

    // A row tag is compared against a row ID of the same width
    localparam int GIN_ROW_TAG_W = 4;

    // A column tag is compared against a column ID of the same width
    localparam int GIN_COL_TAG_W = 4;

    // Default array size used by the top level
    localparam int GIN_ROWS = 3; // Rows of PEs, one row MCC each
    localparam int GIN_COLS = 4; // PEs per row, one column MCC each

endpackage

//--- gin_id_loader.sv
`timescale 1ns/1ps

module gin_id_loader #(
    parameter int ROW_TAG_WIDTH = gin_cfg_pkg::GIN_ROW_TAG_W,
    parameter int COL_TAG_WIDTH = gin_cfg_pkg::GIN_COL_TAG_W,
    parameter int NUM_OF_ROWS   = gin_cfg_pkg::GIN_ROWS,
    parameter int NUM_OF_COLS   = gin_cfg_pkg::GIN_COLS,
    localparam int ID_MAP_W     = NUM_OF_ROWS * (ROW_TAG_WIDTH + NUM_OF_COLS * COL_TAG_WIDTH)
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cfg_start,
    input  logic [ID_MAP_W-1:0] cfg_ids,
    output logic                scan_en_id,
    output logic                scan_bit,
    output logic                cfg_done
);

    import gin_types_pkg::*;

    localparam int CNT_W = $clog2(ID_MAP_W + 1);

    gin_load_state_e     state_q;
    gin_load_state_e     state_d;
    logic [ID_MAP_W-1:0] map_q;  // Map still to be shifted, top bit goes next
    logic [CNT_W-1:0]    cnt_q;  // Bits already sent
    logic                last_bit;

    assign last_bit = (cnt_q == CNT_W'(ID_MAP_W - 1));

    always_comb begin
        state_d = state_q;
        case (state_q)
            LOAD_IDLE,
            LOAD_DONE: if (cfg_start) state_d = LOAD_SHIFT; // A new load may restart
            LOAD_SHIFT: if (last_bit) state_d = LOAD_DONE;
            default: state_d = LOAD_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= LOAD_IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == LOAD_SHIFT) begin
                cnt_q <= cnt_q + 1'b1;
            end else begin
                cnt_q <= '0;
            end
        end
    end

    // Payload register, captured on start and then shifted out
    always_ff @(posedge clk) begin
        if (state_q != LOAD_SHIFT && cfg_start) begin
            map_q <= cfg_ids;
        end else if (state_q == LOAD_SHIFT) begin
            map_q <= map_q << 1;
        end
    end

    // Done follows the FSM by one cycle and drops at once on a restart, so
    // no packet sees a partly shifted map
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg_done <= 1'b0;
        end else begin
            cfg_done <= (state_q == LOAD_DONE) && !cfg_start;
        end
    end

    assign scan_en_id = (state_q == LOAD_SHIFT);
    assign scan_bit   = map_q[ID_MAP_W-1];

endmodule

//--- gin_mcc.sv
`timescale 1ns/1ps

module gin_mcc #(
    parameter int DATA_WIDTH = gin_cfg_pkg::GIN_DATA_W,
    parameter int TAG_WIDTH  = gin_cfg_pkg::GIN_ROW_TAG_W
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [DATA_WIDTH-1:0] data_in,
    input  logic [TAG_WIDTH-1:0]  tag,
    input  logic                  enable_in,
    input  logic                  ready_in,
    input  logic                  scan_en_id,
    input  logic                  scan_in_id,
    output logic [DATA_WIDTH-1:0] data_out,
    output logic                  enable_out,
    output logic                  ready_out,
    output logic                  scan_out_id
);

    logic [TAG_WIDTH-1:0] id_q; // ID of this MCC, filled from the scan chain
    logic                 match;

    // Scan bits move up through the register one position per cycle and the
    // top bit feeds the next MCC. After a full load, every field of the
    // ID map therefore sits in its own MCC with its bit order kept
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_q <= '0;
        end else if (scan_en_id) begin
            id_q <= (id_q << 1) | TAG_WIDTH'(scan_in_id);
        end
    end

    assign scan_out_id = id_q[TAG_WIDTH-1];

    assign match = (tag == id_q);

    // A non-matching MCC never holds traffic back
    assign ready_out = !match || ready_in;

    // Only pass the enable on when the branch below can take the packet
    assign enable_out = enable_in && match && ready_in;

    assign data_out = data_in; // Data is broadcast, the enable marks the targets

endmodule

//--- gin_properties.sv
`timescale 1ns/1ps

module gin_properties #(
    parameter int NUM_OF_ROWS = gin_cfg_pkg::GIN_ROWS,
    parameter int NUM_OF_COLS = gin_cfg_pkg::GIN_COLS
) (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   enable_in,
    input logic [NUM_OF_COLS-1:0] ready_in   [NUM_OF_ROWS],
    input logic [NUM_OF_COLS-1:0] enable_out [NUM_OF_ROWS],
    input logic                   ready_out
);

    for (genvar r = 0; r < NUM_OF_ROWS; r++) begin : g_row
        // A blocked network delivers nothing anywhere
        a_no_enable_when_blocked: assert property (
            @(posedge clk) disable iff (!rst_n) !ready_out |-> (enable_out[r] == '0)
        ) else $error("Row %0d raised an enable while the network was not ready", r);

        a_enable_needs_pe_ready: assert property (
            @(posedge clk) disable iff (!rst_n) ((enable_out[r] & ~ready_in[r]) == '0)
        ) else $error("Row %0d enabled a PE that was not ready", r);

        a_enable_needs_input: assert property (
            @(posedge clk) disable iff (!rst_n) !enable_in |-> (enable_out[r] == '0)
        ) else $error("Row %0d raised an enable without an input enable", r);
    end

endmodule

bind gin gin_properties #(
    .NUM_OF_ROWS (NUM_OF_ROWS),
    .NUM_OF_COLS (NUM_OF_COLS)
) gin_properties_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .enable_in  (enable_in),
    .ready_in   (ready_in),
    .enable_out (enable_out),
    .ready_out  (ready_out)
);

//--- gin_tb.sv
`timescale 1ns/1ps

module gin_tb;

    import gin_cfg_pkg::*;
    import gin_types_pkg::*;

    localparam int ROWS      = 3;
    localparam int COLS      = 4;
    localparam int NUM_PES   = ROWS * COLS;
    localparam int ID_MAP_W  = ROWS * (GIN_ROW_TAG_W + COLS * GIN_COL_TAG_W);
    localparam int NUM_TESTS = 7;
    localparam int TIMEOUT   = 2 * (ID_MAP_W + NUM_TESTS) + 50;
    localparam int SEED      = 32'hb2dd6e30;

    // ID maps are held as nibbles with row 0 and column 0 in the lowest nibble
    // Map A gives rows 0 and 2 the same row ID and repeats column IDs
    localparam logic [ROWS*GIN_ROW_TAG_W-1:0]      MAP_A_ROWS = 12'h353;
    localparam logic [NUM_PES*GIN_COL_TAG_W-1:0]   MAP_A_COLS = 48'h8161_9422_7121;
    localparam logic [ROWS*GIN_ROW_TAG_W-1:0]      MAP_B_ROWS = 12'h935;
    localparam logic [NUM_PES*GIN_COL_TAG_W-1:0]   MAP_B_COLS = 48'h1742_1131_2114;

    typedef struct packed {
        gin_packet_t        pkt;
        logic               valid;
        logic [NUM_PES-1:0] ready_mask; // Bit r*COLS+c is pe_ready of PE (r, c)
        logic               exp_ready;
        logic [NUM_PES-1:0] exp_valid;
    } entry_t;

    logic                  clk;
    logic                  rst_n;
    logic                  cfg_start;
    logic [ID_MAP_W-1:0]   cfg_ids;
    logic                  cfg_done;
    gin_packet_t           pkt;
    logic                  pkt_valid;
    logic                  pkt_ready;
    logic [COLS-1:0]       pe_ready [ROWS];
    logic [COLS-1:0]       pe_valid [ROWS];
    logic [GIN_DATA_W-1:0] pe_data  [ROWS][COLS];
    logic                  scan_out; // End of the scan chain

    logic [ROWS*GIN_ROW_TAG_W-1:0]    row_ids; // Model of the loaded map
    logic [NUM_PES*GIN_COL_TAG_W-1:0] col_ids;

    entry_t stim      [NUM_TESTS];
    string  test_name [NUM_TESTS];
    int     error_cnt;
    int     check_cnt;
    int     test_cnt;
    int     failed_cnt;
    int     cycle_cnt;

    gin_top #(
        .NUM_OF_ROWS (ROWS),
        .NUM_OF_COLS (COLS)
    ) gin_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_start (cfg_start),
        .cfg_ids   (cfg_ids),
        .cfg_done  (cfg_done),
        .pkt       (pkt),
        .pkt_valid (pkt_valid),
        .pkt_ready (pkt_ready),
        .pe_ready  (pe_ready),
        .pe_valid  (pe_valid),
        .pe_data   (pe_data),
        .scan_out  (scan_out)
    );

    always #5 clk = ~clk;

    task automatic check_flag(input logic got, input logic exp, input string what);
        check_cnt++;
        if (got !== exp) begin
            error_cnt++;
            $display("** Error @ %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_valid(input int r, input logic [COLS-1:0] got,
                               input logic [COLS-1:0] exp);
        check_cnt++;
        if (got !== exp) begin
            error_cnt++;
            $display("** Error @ %0t: row %0d pe_valid is %b, expected %b", $time, r, got, exp);
        end
    endtask

    task automatic check_data(input int r, input int c, input logic [GIN_DATA_W-1:0] got,
                              input logic [GIN_DATA_W-1:0] exp);
        check_cnt++;
        if (got !== exp) begin
            error_cnt++;
            $display("** Error @ %0t: PE (%0d,%0d) data is %h, expected %h",
                     $time, r, c, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        check_cnt++;
        if (got != exp) begin
            error_cnt++;
            $display("** Error @ %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string label, input int errs_before);
        test_cnt++;
        if (error_cnt != errs_before) begin
            failed_cnt++;
            $display("%s: FAILED", label);
        end else begin
            $display("%s: ok", label);
        end
    endtask

    // Fields follow the scan chain order with the row 0 row ID at bit 0
    function automatic logic [ID_MAP_W-1:0] build_map();
        logic [ID_MAP_W-1:0] m;
        int                  base;
        m = '0;
        for (int r = 0; r < ROWS; r++) begin
            base = r * (GIN_ROW_TAG_W + COLS * GIN_COL_TAG_W);
            m[base +: GIN_ROW_TAG_W] = row_ids[r*GIN_ROW_TAG_W +: GIN_ROW_TAG_W];
            for (int c = 0; c < COLS; c++) begin
                m[base + GIN_ROW_TAG_W + c*GIN_COL_TAG_W +: GIN_COL_TAG_W] =
                    col_ids[(r*COLS + c)*GIN_COL_TAG_W +: GIN_COL_TAG_W];
            end
        end
        return m;
    endfunction

    function automatic entry_t make_entry(input logic [GIN_ROW_TAG_W-1:0] row_tag,
                                          input logic [GIN_COL_TAG_W-1:0] col_tag,
                                          input logic valid,
                                          input logic [NUM_PES-1:0] ready_mask);
        entry_t e;
        e = '0;
        e.pkt.data    = GIN_DATA_W'($urandom);
        e.pkt.row_tag = row_tag;
        e.pkt.col_tag = col_tag;
        e.valid       = valid;
        e.ready_mask  = ready_mask;
        return e;
    endfunction

    // Reference model of the delivery rule for the map now loaded
    function automatic entry_t with_expected(input entry_t e);
        entry_t             x;
        logic [NUM_PES-1:0] targets;
        x       = e;
        targets = '0;
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                if (row_ids[r*GIN_ROW_TAG_W +: GIN_ROW_TAG_W] == e.pkt.row_tag &&
                    col_ids[(r*COLS + c)*GIN_COL_TAG_W +: GIN_COL_TAG_W] == e.pkt.col_tag) begin
                    targets[r*COLS + c] = 1'b1;
                end
            end
        end
        x.exp_ready = ((targets & ~e.ready_mask) == '0); // Idle PEs never stall
        x.exp_valid = (e.valid && x.exp_ready) ? targets : '0;
        return x;
    endfunction

    task automatic build_table();
        stim[0] = make_entry(4'h5, 4'h4, 1'b1, 12'hfff);
        test_name[0] = "unicast";
        stim[1] = make_entry(4'h3, 4'h1, 1'b1, 12'hfff);
        test_name[1] = "multicast over two rows";
        stim[2] = make_entry(4'ha, 4'h5, 1'b1, 12'h000);
        test_name[2] = "no match, all PEs busy";
        stim[3] = make_entry(4'h3, 4'h1, 1'b1, 12'hbff);
        test_name[3] = "multicast, PE (2,2) busy";
        stim[4] = make_entry(4'h5, 4'h2, 1'b1, 12'h7fe);
        test_name[4] = "PEs (0,0) and (2,3) busy";
        stim[5] = make_entry(4'h5, 4'h4, 1'b0, 12'hfff);
        test_name[5] = "valid low";
        stim[6] = make_entry(4'h3, 4'h7, 1'b1, 12'hfff);
        test_name[6] = "unicast, last column";
    endtask

    task automatic drive_ready(input logic [NUM_PES-1:0] mask);
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                pe_ready[r][c] = mask[r*COLS + c];
            end
        end
    endtask

    task automatic check_reset_state();
        int errs_before;
        errs_before = error_cnt;
        pkt       = stim[1].pkt;
        pkt_valid = 1'b1; // Must stay blocked while the loader is idle
        @(negedge clk);
        check_flag(pkt_ready, 1'b0, "pkt_ready after reset");
        check_flag(cfg_done, 1'b0, "cfg_done after reset");
        check_flag(scan_out, 1'b0, "scan_out after reset"); // All ID registers are clear
        for (int r = 0; r < ROWS; r++) begin
            check_valid(r, pe_valid[r], '0);
        end
        report_test("reset state", errs_before);
    endtask

    task automatic load_ids(input string label);
        int cycles;
        int errs_before;
        errs_before = error_cnt;
        @(posedge clk);
        #1;
        cfg_ids   = build_map();
        cfg_start = 1'b1;
        pkt       = stim[1].pkt;
        pkt_valid = 1'b1;
        drive_ready('1);
        @(posedge clk); // Loader takes the start here
        #1;
        cfg_start = 1'b0;
        cycles    = 0;
        @(negedge clk);
        while (!cfg_done && cycles < 2 * ID_MAP_W) begin
            check_flag(pkt_ready, 1'b0, "pkt_ready during load");
            for (int r = 0; r < ROWS; r++) begin
                check_valid(r, pe_valid[r], '0);
            end
            @(posedge clk);
            cycles++;
            @(negedge clk);
        end
        if (!cfg_done) begin
            error_cnt++;
            $display("Load of %s never raised cfg_done", label);
        end else begin
            check_count(cycles, ID_MAP_W + 1, "cycles from cfg_start to cfg_done");
            // The first bit shifted in has reached the far end of the chain
            check_flag(scan_out, cfg_ids[ID_MAP_W-1], "scan_out after load");
        end
        report_test({"load of ", label}, errs_before);
    endtask

    task automatic run_table(input string label);
        entry_t e;
        int     errs_before;
        for (int i = 0; i < NUM_TESTS; i++) begin
            e = with_expected(stim[i]);
            errs_before = error_cnt;
            @(posedge clk);
            #1;
            pkt       = e.pkt;
            pkt_valid = e.valid;
            drive_ready(e.ready_mask);
            @(negedge clk); // Outputs of the combinational network have settled here
            check_flag(pkt_ready, e.exp_ready, "pkt_ready");
            for (int r = 0; r < ROWS; r++) begin
                check_valid(r, pe_valid[r], e.exp_valid[r*COLS +: COLS]);
                for (int c = 0; c < COLS; c++) begin
                    if (e.exp_valid[r*COLS + c]) begin
                        check_data(r, c, pe_data[r][c], e.pkt.data);
                    end
                end
            end
            report_test($sformatf("%s test %0d (%s)", label, i, test_name[i]), errs_before);
        end
        @(posedge clk);
        #1;
        pkt_valid = 1'b0;
        drive_ready('1);
    endtask

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        clk        = 1'b0;
        rst_n      = 1'b0;
        cfg_start  = 1'b0;
        cfg_ids    = '0;
        pkt        = '0;
        pkt_valid  = 1'b0;
        drive_ready('1);
        error_cnt  = 0;
        check_cnt  = 0;
        test_cnt   = 0;
        failed_cnt = 0;
        build_table();
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_reset_state();
        row_ids = MAP_A_ROWS;
        col_ids = MAP_A_COLS;
        load_ids("map A");
        run_table("map A");
        row_ids = MAP_B_ROWS; // The same packets now go to the target sets of map B
        col_ids = MAP_B_COLS;
        load_ids("map B");
        run_table("map B");
        $display("Tests: %0d, failed tests: %0d, checks: %0d, errors: %0d",
                 test_cnt, failed_cnt, check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- gin_top.sv
`timescale 1ns/1ps

module gin_top #(
    parameter int DATA_WIDTH    = gin_cfg_pkg::GIN_DATA_W,
    parameter int ROW_TAG_WIDTH = gin_cfg_pkg::GIN_ROW_TAG_W,
    parameter int COL_TAG_WIDTH = gin_cfg_pkg::GIN_COL_TAG_W,
    parameter int NUM_OF_ROWS   = gin_cfg_pkg::GIN_ROWS,
    parameter int NUM_OF_COLS   = gin_cfg_pkg::GIN_COLS,
    localparam int ID_MAP_W     = NUM_OF_ROWS * (ROW_TAG_WIDTH + NUM_OF_COLS * COL_TAG_WIDTH)
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cfg_start,
    input  logic [ID_MAP_W-1:0]        cfg_ids,
    output logic                       cfg_done,
    input  gin_types_pkg::gin_packet_t pkt,
    input  logic                       pkt_valid,
    output logic                       pkt_ready,
    input  logic [NUM_OF_COLS-1:0]     pe_ready [NUM_OF_ROWS],
    output logic [NUM_OF_COLS-1:0]     pe_valid [NUM_OF_ROWS],
    output logic [DATA_WIDTH-1:0]      pe_data  [NUM_OF_ROWS][NUM_OF_COLS],
    output logic                       scan_out
);

    logic scan_en_id;
    logic scan_bit;   // Loader output feeding row 0 MCC
    logic gin_ready;

    gin_id_loader #(
        .ROW_TAG_WIDTH (ROW_TAG_WIDTH),
        .COL_TAG_WIDTH (COL_TAG_WIDTH),
        .NUM_OF_ROWS   (NUM_OF_ROWS),
        .NUM_OF_COLS   (NUM_OF_COLS)
    ) id_loader_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg_start  (cfg_start),
        .cfg_ids    (cfg_ids),
        .scan_en_id (scan_en_id),
        .scan_bit   (scan_bit),
        .cfg_done   (cfg_done)
    );

    gin #(
        .DATA_WIDTH    (DATA_WIDTH),
        .ROW_TAG_WIDTH (ROW_TAG_WIDTH),
        .COL_TAG_WIDTH (COL_TAG_WIDTH),
        .NUM_OF_ROWS   (NUM_OF_ROWS),
        .NUM_OF_COLS   (NUM_OF_COLS)
    ) gin_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .pkt         (pkt),
        .enable_in   (pkt_valid && cfg_done), // Traffic waits for a complete map
        .ready_in    (pe_ready),
        .scan_en_id  (scan_en_id),
        .scan_in_id  (scan_bit),
        .data_out    (pe_data),
        .enable_out  (pe_valid),
        .ready_out   (gin_ready),
        .scan_out_id (scan_out)
    );

    assign pkt_ready = gin_ready && cfg_done;

endmodule

//--- gin_types_pkg.sv
package gin_types_pkg;

    // One tagged packet, data in the upper bits and the tag pair below
    typedef struct packed {
        logic [gin_cfg_pkg::GIN_DATA_W-1:0]    data;
        logic [gin_cfg_pkg::GIN_ROW_TAG_W-1:0] row_tag; // Selects rows by row ID
        logic [gin_cfg_pkg::GIN_COL_TAG_W-1:0] col_tag; // Selects columns by column ID
    } gin_packet_t;

    // ID loader FSM
    typedef enum logic [1:0] {
        LOAD_IDLE  = 2'd0, // Nothing loaded since reset
        LOAD_SHIFT = 2'd1, // Scan chain is being filled
        LOAD_DONE  = 2'd2  // Map in place, traffic may flow
    } gin_load_state_e;

endpackage

//--- gin_xbus.sv
`timescale 1ns/1ps

module gin_xbus #(
    parameter int DATA_WIDTH    = gin_cfg_pkg::GIN_DATA_W,
    parameter int COL_TAG_WIDTH = gin_cfg_pkg::GIN_COL_TAG_W,
    parameter int NUM_OF_COLS   = gin_cfg_pkg::GIN_COLS
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [DATA_WIDTH-1:0]    data_in,
    input  logic [COL_TAG_WIDTH-1:0] col_tag,
    input  logic                     enable_in,
    input  logic [NUM_OF_COLS-1:0]   ready_in,
    input  logic                     scan_en_id,
    input  logic                     scan_in_id,
    output logic [DATA_WIDTH-1:0]    data_out [NUM_OF_COLS],
    output logic [NUM_OF_COLS-1:0]   enable_out,
    output logic                     ready_out,
    output logic                     scan_out_id
);

    logic [NUM_OF_COLS-1:0] col_ready;  // One ready per column MCC
    logic [NUM_OF_COLS:0]   scan_chain; // Links column 0 up to the last column

    assign scan_chain[0] = scan_in_id;
    assign scan_out_id   = scan_chain[NUM_OF_COLS];

    for (genvar c = 0; c < NUM_OF_COLS; c++) begin : g_col
        gin_mcc #(
            .DATA_WIDTH (DATA_WIDTH),
            .TAG_WIDTH  (COL_TAG_WIDTH)
        ) col_mcc_i (
            .clk         (clk),
            .rst_n       (rst_n),
            .data_in     (data_in),
            .tag         (col_tag),
            .enable_in   (enable_in),
            .ready_in    (ready_in[c]),
            .scan_en_id  (scan_en_id),
            .scan_in_id  (scan_chain[c]),
            .data_out    (data_out[c]),
            .enable_out  (enable_out[c]),
            .ready_out   (col_ready[c]),
            .scan_out_id (scan_chain[c+1])
        );
    end

    // The row can accept only when every column that matches is ready
    assign ready_out = &col_ready;

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module gin_tb -f all.f --Mdir obj_dir -o gin_sim

# The log decides the result, so a nonzero exit of the model is not fatal here
./obj_dir/gin_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx '\*\* PASS \*\*' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
